// ==== verilog/frame_pkg.sv ====
package frame_pkg;

    // =========================================================================
    // Stream and frame geometry
    // =========================================================================

    // One stream beat carries a single byte
    localparam int BYTE_W = 8;

    // Bytes in the big field, following the table id
    localparam int FIELD_LEN = 16;

    // Credits per link, also the depth of the input buffer
    localparam int CREDIT_DEPTH = 4;

    // Pointer width for the circular input buffer
    localparam int PTR_W = $clog2(CREDIT_DEPTH);

    // =========================================================================
    // Types
    // =========================================================================

    typedef logic [BYTE_W-1:0] byte_t;

    // Byte index 0 of the field sits in the most significant byte
    typedef logic [FIELD_LEN*BYTE_W-1:0] field_t;

    typedef logic [3:0] field_index_t;

    // Counts 0 to CREDIT_DEPTH inclusive
    typedef logic [2:0] credit_count_t;

    typedef logic [PTR_W-1:0] buf_ptr_t;

    // Region of the frame the next byte belongs to
    typedef enum logic [1:0] {
        seq_id,
        seq_field,
        seq_payload
    } seq_state_t;

endpackage

// ==== verilog/credit_receiver.sv ====
`timescale 1ns/100ps

module credit_receiver (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                in_valid,
    input  frame_pkg::byte_t    in_data,
    input  logic                in_last,
    output logic                in_credit,
    input  logic                pop,
    output logic                buf_valid,
    output frame_pkg::byte_t    buf_data,
    output logic                buf_last
);

    // Buffer storage, one entry per credit handed to upstream
    frame_pkg::byte_t data_mem [frame_pkg::CREDIT_DEPTH];
    logic             last_mem [frame_pkg::CREDIT_DEPTH];

    frame_pkg::buf_ptr_t      wr_ptr;
    frame_pkg::buf_ptr_t      rd_ptr;
    frame_pkg::credit_count_t count;

    // =========================================================================
    // Storage write
    // =========================================================================

    // Upstream only sends against a credit, so a write always finds room
    always_ff @(posedge clock) begin
        if (in_valid) begin
            data_mem[wr_ptr] <= in_data;
            last_mem[wr_ptr] <= in_last;
        end
    end

    // =========================================================================
    // Pointers, occupancy and credit return
    // =========================================================================

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= frame_pkg::buf_ptr_t'(wr_ptr + 1'b1);
            end
            if (pop) begin
                rd_ptr <= frame_pkg::buf_ptr_t'(rd_ptr + 1'b1);
            end

            case ({in_valid, pop})
                2'b10:   count <= frame_pkg::credit_count_t'(count + 1'b1);
                2'b01:   count <= frame_pkg::credit_count_t'(count - 1'b1);
                default: count <= count;
            endcase

            // Each consumed byte frees one slot for upstream
            in_credit <= pop;
        end
    end

    // Head of the buffer
    assign buf_valid = (count != '0);
    assign buf_data  = data_mem[rd_ptr];
    assign buf_last  = last_mem[rd_ptr];

endmodule

// ==== verilog/frame_sequencer.sv ====
`timescale 1ns/100ps

module frame_sequencer (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    buf_valid,
    input  logic                    buf_last,
    input  logic                    send_ready,
    output logic                    pop,
    output logic                    id_write,
    output logic                    field_write,
    output frame_pkg::field_index_t field_index,
    output logic                    payload_send,
    output logic                    payload_last,
    output logic                    frame_error
);

    localparam frame_pkg::field_index_t LAST_INDEX =
        frame_pkg::field_index_t'(frame_pkg::FIELD_LEN - 1);

    frame_pkg::seq_state_t   state;
    frame_pkg::seq_state_t   state_next;
    frame_pkg::field_index_t index_next;
    logic                    early_end;

    // =========================================================================
    // Consume decision and region strobes
    // =========================================================================

    // Id and field bytes never stall; payload waits for an output credit
    assign pop = buf_valid && ((state != frame_pkg::seq_payload) || send_ready);

    assign id_write     = pop && (state == frame_pkg::seq_id);
    assign field_write  = pop && (state == frame_pkg::seq_field);
    assign payload_send = pop && (state == frame_pkg::seq_payload);
    assign payload_last = payload_send && buf_last;

    // Frame closed before the final field byte was written
    assign early_end = pop && buf_last &&
        ((state == frame_pkg::seq_id) ||
         ((state == frame_pkg::seq_field) && (field_index != LAST_INDEX)));

    // =========================================================================
    // Next state
    // =========================================================================

    always_comb begin
        state_next = state;
        index_next = field_index;

        if (pop) begin
            case (state)
                frame_pkg::seq_id: begin
                    // A one byte frame stays in the id region
                    if (!buf_last) begin
                        state_next = frame_pkg::seq_field;
                        index_next = '0;
                    end
                end
                frame_pkg::seq_field: begin
                    if (buf_last) begin
                        state_next = frame_pkg::seq_id;
                    end else if (field_index == LAST_INDEX) begin
                        state_next = frame_pkg::seq_payload;
                    end else begin
                        index_next = frame_pkg::field_index_t'(field_index + 1'b1);
                    end
                end
                frame_pkg::seq_payload: begin
                    if (buf_last) begin
                        state_next = frame_pkg::seq_id;
                    end
                end
                default: begin
                    state_next = frame_pkg::seq_id;
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state       <= frame_pkg::seq_id;
            field_index <= '0;
            frame_error <= 1'b0;
        end else begin
            state       <= state_next;
            field_index <= index_next;
            // One cycle pulse after the byte that ends a frame early
            frame_error <= early_end;
        end
    end

endmodule

// ==== verilog/field_capture.sv ====
`timescale 1ns/100ps

module field_capture (
    input  logic                    clock,
    input  logic                    rst_n,
    input  frame_pkg::byte_t        buf_data,
    input  logic                    id_write,
    input  logic                    field_write,
    input  frame_pkg::field_index_t field_index,
    output frame_pkg::byte_t        table_id,
    output frame_pkg::field_t       field_value,
    output logic                    field_valid
);

    localparam frame_pkg::field_index_t LAST_INDEX =
        frame_pkg::field_index_t'(frame_pkg::FIELD_LEN - 1);

    // One entry per field byte, entry 0 is the first byte on the stream
    frame_pkg::byte_t field_bytes [frame_pkg::FIELD_LEN];

    // =========================================================================
    // Id and field storage
    // =========================================================================

    always_ff @(posedge clock) begin
        if (id_write) begin
            table_id <= buf_data;
        end
        if (field_write) begin
            field_bytes[field_index] <= buf_data;
        end
    end

    // Pack the array with byte 0 in the top byte lane
    always_comb begin
        for (int i = 0; i < frame_pkg::FIELD_LEN; i++) begin
            field_value[(frame_pkg::FIELD_LEN-1-i)*frame_pkg::BYTE_W +: frame_pkg::BYTE_W] =
                field_bytes[i];
        end
    end

    // =========================================================================
    // Completion flag
    // =========================================================================

    // Only a frame that reaches the final index gets here
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            field_valid <= 1'b0;
        end else begin
            field_valid <= field_write && (field_index == LAST_INDEX);
        end
    end

endmodule

// ==== verilog/payload_sender.sv ====
`timescale 1ns/100ps

module payload_sender (
    input  logic             clock,
    input  logic             rst_n,
    input  frame_pkg::byte_t buf_data,
    input  logic             payload_send,
    input  logic             payload_last,
    input  logic             out_credit,
    output logic             send_ready,
    output logic             out_valid,
    output frame_pkg::byte_t out_data,
    output logic             out_last
);

    localparam frame_pkg::credit_count_t FULL_CREDITS =
        frame_pkg::credit_count_t'(frame_pkg::CREDIT_DEPTH);

    frame_pkg::credit_count_t credits;

    // The only place that tests the downstream credit count
    assign send_ready = (credits != '0);

    // =========================================================================
    // Output credit counter
    // =========================================================================

    // A send and a returned credit in one cycle leave the count unchanged
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            credits <= FULL_CREDITS;
        end else begin
            case ({payload_send, out_credit})
                2'b10:   credits <= frame_pkg::credit_count_t'(credits - 1'b1);
                2'b01:   credits <= frame_pkg::credit_count_t'(credits + 1'b1);
                default: credits <= credits;
            endcase
        end
    end

    // =========================================================================
    // Output register
    // =========================================================================

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= payload_send;
            out_last  <= payload_send && payload_last;
        end
    end

    always_ff @(posedge clock) begin
        if (payload_send) begin
            out_data <= buf_data;
        end
    end

endmodule

// ==== verilog/frame_table_parser.sv ====
`timescale 1ns/100ps

module frame_table_parser (
    input  logic              clock,
    input  logic              rst_n,
    // Upstream link
    input  logic              in_valid,
    input  frame_pkg::byte_t  in_data,
    input  logic              in_last,
    output logic              in_credit,
    // Downstream link
    output logic              out_valid,
    output frame_pkg::byte_t  out_data,
    output logic              out_last,
    input  logic              out_credit,
    // Parsed frame table entry
    output frame_pkg::byte_t  table_id,
    output frame_pkg::field_t field_value,
    output logic              field_valid,
    output logic              frame_error
);

    logic                    buf_valid;
    frame_pkg::byte_t        buf_data;
    logic                    buf_last;
    logic                    pop;
    logic                    id_write;
    logic                    field_write;
    frame_pkg::field_index_t field_index;
    logic                    payload_send;
    logic                    payload_last;
    logic                    send_ready;

    credit_receiver i_credit_receiver (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_credit (in_credit),
        .pop       (pop),
        .buf_valid (buf_valid),
        .buf_data  (buf_data),
        .buf_last  (buf_last)
    );

    frame_sequencer i_frame_sequencer (
        .clock        (clock),
        .rst_n        (rst_n),
        .buf_valid    (buf_valid),
        .buf_last     (buf_last),
        .send_ready   (send_ready),
        .pop          (pop),
        .id_write     (id_write),
        .field_write  (field_write),
        .field_index  (field_index),
        .payload_send (payload_send),
        .payload_last (payload_last),
        .frame_error  (frame_error)
    );

    field_capture i_field_capture (
        .clock       (clock),
        .rst_n       (rst_n),
        .buf_data    (buf_data),
        .id_write    (id_write),
        .field_write (field_write),
        .field_index (field_index),
        .table_id    (table_id),
        .field_value (field_value),
        .field_valid (field_valid)
    );

    payload_sender i_payload_sender (
        .clock        (clock),
        .rst_n        (rst_n),
        .buf_data     (buf_data),
        .payload_send (payload_send),
        .payload_last (payload_last),
        .out_credit   (out_credit),
        .send_ready   (send_ready),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_last     (out_last)
    );

endmodule

// ==== test/frame_table_parser_assert.sv ====
`timescale 1ns/100ps

module frame_table_parser_assert (
    input logic                     clock,
    input logic                     rst_n,
    input frame_pkg::credit_count_t rx_count,
    input frame_pkg::credit_count_t tx_credits,
    input logic                     out_valid,
    input logic                     field_valid,
    input logic                     frame_error
);

    // Buffer never holds more bytes than credits handed upstream
    a_rx_occupancy: assert property (@(posedge clock) disable iff (!rst_n)
        rx_count <= frame_pkg::CREDIT_DEPTH)
        else $error("Receiver occupancy above the credit depth");

    a_tx_credits: assert property (@(posedge clock) disable iff (!rst_n)
        tx_credits <= frame_pkg::CREDIT_DEPTH)
        else $error("Sender credit count above the credit depth");

    // Output register lags the send by one cycle
    a_send_credit: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> ($past(tx_credits) != '0))
        else $error("Byte sent downstream with no credit");

    a_flag_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
        !(field_valid && frame_error))
        else $error("field_valid and frame_error high together");

endmodule

bind frame_table_parser frame_table_parser_assert i_assert (
    .clock       (clock),
    .rst_n       (rst_n),
    .rx_count    (i_credit_receiver.count),
    .tx_credits  (i_payload_sender.credits),
    .out_valid   (out_valid),
    .field_valid (field_valid),
    .frame_error (frame_error)
);

// ==== test/frame_table_parser_tb.sv ====
`timescale 1ns/100ps

module frame_table_parser_tb;

    localparam int NUM_TESTS = 12;
    localparam int TIMEOUT = 5000;

    logic              clock = 1'b0;
    logic              rst_n;
    logic              in_valid;
    frame_pkg::byte_t  in_data;
    logic              in_last;
    logic              in_credit;
    logic              out_valid;
    frame_pkg::byte_t  out_data;
    logic              out_last;
    logic              out_credit;
    frame_pkg::byte_t  table_id;
    frame_pkg::field_t field_value;
    logic              field_valid;
    logic              frame_error;

    // Columns are name, table id, frame length, downstream delay limit, wait for idle
    string test_name [NUM_TESTS] = '{"field_only", "payload_short", "payload_long",
        "early_end_field", "early_end_id", "early_end_index_14", "after_error",
        "slow_downstream", "b2b_first", "b2b_error", "b2b_second", "b2b_third"};
    frame_pkg::byte_t test_id [NUM_TESTS] = '{8'h11, 8'h22, 8'h23, 8'h30, 8'h31, 8'h32,
        8'h33, 8'h40, 8'h51, 8'h52, 8'h53, 8'h54};
    int test_len [NUM_TESTS] = '{17, 20, 40, 10, 1, 16, 18, 50, 17, 6, 24, 17};
    int test_delay [NUM_TESTS] = '{0, 1, 3, 0, 0, 0, 0, 30, 0, 2, 5, 0};
    bit test_wait [NUM_TESTS] = '{1, 1, 1, 1, 1, 1, 1, 1, 0, 0, 0, 1};

    frame_pkg::byte_t  tx_data [$];
    logic              tx_last [$];
    frame_pkg::byte_t  exp_ids [$];
    frame_pkg::byte_t  got_ids [$];
    frame_pkg::field_t exp_fields [$];
    frame_pkg::field_t got_fields [$];
    frame_pkg::byte_t  exp_pay [$];
    frame_pkg::byte_t  got_pay [$];
    logic              exp_plast [$];
    logic              got_plast [$];
    string             field_owner [$];
    string             pay_owner [$];
    int                exp_errors;
    int                got_errors;
    int                up_credits;
    int                pending;
    int                hold;
    int                delay_limit;
    logic [15:0]       data_lfsr;
    logic [15:0]       delay_lfsr;

    frame_table_parser i_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .in_last     (in_last),
        .in_credit   (in_credit),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_credit  (out_credit),
        .table_id    (table_id),
        .field_value (field_value),
        .field_valid (field_valid),
        .frame_error (frame_error)
    );

    always #50 clock = ~clock;

    // =========================================================================
    // Helpers and compare tasks
    // =========================================================================

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, inout logic [15:0] s, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_step(s);
            value = (value << 1) | s[0];
        end
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input frame_pkg::byte_t exp,
                              input frame_pkg::byte_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_field(input string name, input frame_pkg::field_t exp,
                               input frame_pkg::field_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input string what, input int exp,
                               input int act);
        if (act != exp) begin
            stop_run($sformatf("FAIL %s %s: expected %0d, actual %0d", name, what, exp, act));
        end
    endtask

    // =========================================================================
    // Link models, driven and sampled on the falling edge
    // =========================================================================

    // Upstream sends a queued byte only while it holds a credit
    always @(negedge clock) begin
        if (rst_n) begin
            if (in_credit) begin
                up_credits++;
            end
            if (up_credits > frame_pkg::CREDIT_DEPTH) begin
                stop_run("Upstream was handed more credits than the link depth");
            end
            in_valid = 1'b0;
            if ((tx_data.size() > 0) && (up_credits > 0)) begin
                in_valid = 1'b1;
                in_data = tx_data.pop_front();
                in_last = tx_last.pop_front();
                up_credits--;
            end
        end
    end

    // Downstream collects outputs and returns credits after a random delay
    always @(negedge clock) begin
        out_credit = 1'b0;
        if (rst_n) begin
            if (out_valid) begin
                got_pay.push_back(out_data);
                got_plast.push_back(out_last);
                pending++;
                if (pending > frame_pkg::CREDIT_DEPTH) begin
                    stop_run("Downstream received a byte it had no credit out for");
                end
            end
            if (pending > 0) begin
                if (hold == 0) begin
                    out_credit = 1'b1;
                    pending--;
                    draw_bits(6, delay_lfsr, hold);
                    hold = hold % (delay_limit + 1);
                end else begin
                    hold--;
                end
            end
            if (field_valid) begin
                got_fields.push_back(field_value);
                got_ids.push_back(table_id);
            end
            if (frame_error) begin
                got_errors++;
            end
        end
    end

    // =========================================================================
    // Reference model and result checks
    // =========================================================================

    task automatic queue_frame(input int t);
        frame_pkg::field_t field;
        frame_pkg::byte_t  b;
        int                value;
        field = '0;
        for (int p = 0; p < test_len[t]; p++) begin
            b = test_id[t];
            if (p > 0) begin
                draw_bits(frame_pkg::BYTE_W, data_lfsr, value);
                b = frame_pkg::byte_t'(value);
            end
            tx_data.push_back(b);
            tx_last.push_back(p == test_len[t] - 1);
            // First field byte ends up in the top byte lane
            if ((p >= 1) && (p <= frame_pkg::FIELD_LEN)) begin
                field = (field << frame_pkg::BYTE_W) | frame_pkg::field_t'(b);
            end else if (p > frame_pkg::FIELD_LEN) begin
                exp_pay.push_back(b);
                exp_plast.push_back(p == test_len[t] - 1);
                pay_owner.push_back(test_name[t]);
            end
        end
        if (test_len[t] > frame_pkg::FIELD_LEN) begin
            exp_fields.push_back(field);
            exp_ids.push_back(test_id[t]);
            field_owner.push_back(test_name[t]);
        end else begin
            exp_errors++;
        end
    endtask

    task automatic wait_idle(input string name);
        int cycles;
        cycles = 0;
        while ((tx_data.size() != 0) || (up_credits != frame_pkg::CREDIT_DEPTH) ||
               (got_fields.size() < exp_fields.size()) ||
               (got_pay.size() < exp_pay.size()) || (got_errors < exp_errors)) begin
            @(posedge clock);
            cycles++;
            if (cycles > TIMEOUT) begin
                if ((tx_data.size() != 0) || (up_credits != frame_pkg::CREDIT_DEPTH)) begin
                    stop_run({"Timeout in ", name, ": input bytes were never all consumed"});
                end else if (got_fields.size() < exp_fields.size()) begin
                    stop_run({"Timeout in ", name, ": field_valid never came"});
                end else if (got_pay.size() < exp_pay.size()) begin
                    stop_run({"Timeout in ", name, ": payload bytes never reached out_valid"});
                end else begin
                    stop_run({"Timeout in ", name, ": frame_error never pulsed"});
                end
            end
        end
        // Quiet stretch so that stray outputs show up in the counts
        repeat (8) @(posedge clock);
    endtask

    task automatic compare_results(input string name);
        string owner;
        check_count(name, "field_valid pulses", exp_fields.size(), got_fields.size());
        check_count(name, "payload bytes", exp_pay.size(), got_pay.size());
        check_count(name, "frame_error pulses", exp_errors, got_errors);
        while (exp_fields.size() > 0) begin
            owner = field_owner.pop_front();
            check_byte(owner, exp_ids.pop_front(), got_ids.pop_front());
            check_field(owner, exp_fields.pop_front(), got_fields.pop_front());
        end
        while (exp_pay.size() > 0) begin
            owner = pay_owner.pop_front();
            check_byte(owner, exp_pay.pop_front(), got_pay.pop_front());
            check_flag(owner, exp_plast.pop_front(), got_plast.pop_front());
        end
        exp_errors = 0;
        got_errors = 0;
    endtask

    initial begin
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_last = 1'b0;
        out_credit = 1'b0;
        up_credits = frame_pkg::CREDIT_DEPTH;
        pending = 0;
        hold = 0;
        delay_limit = 0;
        exp_errors = 0;
        got_errors = 0;
        data_lfsr = 16'd59;
        delay_lfsr = 16'd59;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        @(posedge clock);

        for (int t = 0; t < NUM_TESTS; t++) begin
            delay_limit = test_delay[t];
            queue_frame(t);
            if (test_wait[t]) begin
                wait_idle(test_name[t]);
                compare_results(test_name[t]);
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/frame_pkg.sv
verilog/credit_receiver.sv
verilog/frame_sequencer.sv
verilog/field_capture.sv
verilog/payload_sender.sv
verilog/frame_table_parser.sv
test/frame_table_parser_assert.sv
test/frame_table_parser_tb.sv

// ==== Bender.yml ====
package:
  name: frame_table_parser

sources:
  - verilog/frame_pkg.sv
  - verilog/credit_receiver.sv
  - verilog/frame_sequencer.sv
  - verilog/field_capture.sv
  - verilog/payload_sender.sv
  - verilog/frame_table_parser.sv
  - target: test
    files:
      - test/frame_table_parser_assert.sv
      - test/frame_table_parser_tb.sv
